//--- common/trace_core_pkg.sv
/*
 * trace core package
 * types for the retirement port between the core and the trace encoder
 */
package trace_core_pkg;

    // instruction address width of the core
    parameter int unsigned IADDR_LEN = 32;

    // class of the retired instruction as seen by the encoder
    typedef enum logic [1:0] {
        ICLASS_PLAIN      = 2'd0,
        ICLASS_BRANCH     = 2'd1,
        ICLASS_JUMP_UNINF = 2'd2
    } iclass_e;

    // one retirement report, strobed by valid
    // taken only means something for ICLASS_BRANCH
    typedef struct packed {
        logic                 valid;
        logic [IADDR_LEN-1:0] iaddr;
        iclass_e              iclass;
        logic                 taken;
    } retire_s;

endpackage

//--- common/trace_pkt_pkg.sv
/*
 * trace packet package
 * packet opcodes and the layout of one outgoing trace packet
 */
package trace_pkt_pkg;

    // map field width, the deepest branch map supported
    parameter int unsigned MAP_FIELD_LEN = 31;

    // width of the branch count field
    parameter int unsigned BRANCHES_LEN = 5;

    // width of the packet address field
    parameter int unsigned PKT_ADDR_LEN = 32;

    // packet opcode
    typedef enum logic [1:0] {
        FMT_START  = 2'd0,  // full address after sync
        FMT_BRANCH = 2'd1,  // full branch map, no address
        FMT_ADDR   = 2'd2   // differential address plus pending map
    } pkt_format_e;

    // one trace packet
    // map bit 0 is the oldest branch, 0 means taken
    typedef struct packed {
        pkt_format_e              format;
        logic [BRANCHES_LEN-1:0]  branches;
        logic [MAP_FIELD_LEN-1:0] map;
        logic [PKT_ADDR_LEN-1:0]  address;
    } trace_pkt_s;

endpackage

//--- encoder/packet_emitter.sv
/*
 * packet emitter
 * builds the outgoing packet from the chosen format and registers it
 */
module packet_emitter import trace_pkt_pkg::*; (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     emit_i,
    input  pkt_format_e              fmt_i,
    input  logic [MAP_FIELD_LEN-1:0] map_i,
    input  logic [BRANCHES_LEN-1:0]  branches_i,
    input  logic [31:0]              iaddr_i,
    input  logic [31:0]              delta_i,
    output logic                     pkt_valid_o,
    output trace_pkt_s               pkt_o
);

    trace_pkt_s pkt_d;
    trace_pkt_s pkt_q;
    logic       valid_q;

    always_comb begin
        pkt_d.format   = fmt_i;
        pkt_d.branches = branches_i;
        pkt_d.map      = map_i;
        case (fmt_i)
            FMT_START: begin
                // start carries no branch history
                pkt_d.branches = '0;
                pkt_d.map      = '0;
                pkt_d.address  = iaddr_i;
            end
            FMT_ADDR: begin
                pkt_d.address = delta_i;
            end
            default: begin
                pkt_d.address = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= emit_i;
        end
    end

    always_ff @(posedge clk) begin
        if (emit_i) begin
            pkt_q <= pkt_d;
        end
    end

    assign pkt_valid_o = valid_q;
    assign pkt_o       = pkt_q;

endmodule

//--- encoder/packet_select.sv
/*
 * packet select
 * tracing FSM deciding when a packet goes out, which format it has and when the map flushes
 */
module packet_select import trace_core_pkg::*, trace_pkt_pkg::*; #(
    parameter int unsigned MAP_LEN = 31
) (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        enable_i,
    input  retire_s     retire_i,
    input  logic        map_full_i,
    output logic        map_push_o,
    output logic        map_taken_o,
    output logic        map_flush_o,
    output logic        addr_load_o,
    output logic        emit_o,
    output pkt_format_e emit_fmt_o
);

    typedef enum logic [1:0] {
        ST_OFF  = 2'd0,
        ST_SYNC = 2'd1,
        ST_RUN  = 2'd2
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   is_branch;
    logic   is_jump;

    // map depth has to fit the packet map field
    if (MAP_LEN < 1 || MAP_LEN > MAP_FIELD_LEN) begin : g_map_len_check
        $error("packet_select: MAP_LEN %0d outside 1..%0d", MAP_LEN, MAP_FIELD_LEN);
    end

    assign is_branch = retire_i.valid && (retire_i.iclass == ICLASS_BRANCH);
    assign is_jump   = retire_i.valid && (retire_i.iclass == ICLASS_JUMP_UNINF);

    always_comb begin
        state_d     = state_q;
        map_push_o  = 1'b0;
        map_flush_o = 1'b0;
        addr_load_o = 1'b0;
        emit_o      = 1'b0;
        emit_fmt_o  = FMT_BRANCH;

        if (!enable_i) begin
            // tracing off, drop everything
            state_d     = ST_OFF;
            map_flush_o = 1'b1;
        end else begin
            case (state_q)
                ST_OFF, ST_SYNC: begin
                    state_d = ST_SYNC;
                    // first retirement after enable gives the start packet
                    if (retire_i.valid) begin
                        state_d     = ST_RUN;
                        emit_o      = 1'b1;
                        emit_fmt_o  = FMT_START;
                        map_flush_o = 1'b1;
                        addr_load_o = 1'b1;
                        map_push_o  = is_branch;
                    end
                end
                ST_RUN: begin
                    map_push_o = is_branch;
                    if (is_jump) begin
                        // jump wins over a full map, its packet carries the map anyway
                        emit_o      = 1'b1;
                        emit_fmt_o  = FMT_ADDR;
                        map_flush_o = 1'b1;
                        addr_load_o = 1'b1;
                    end else if (map_full_i) begin
                        emit_o      = 1'b1;
                        emit_fmt_o  = FMT_BRANCH;
                        map_flush_o = 1'b1;
                    end
                end
                default: begin
                    state_d = ST_OFF;
                end
            endcase
        end
    end

    assign map_taken_o = retire_i.taken;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_OFF;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

//--- encoder/trace_encoder.sv
/*
 * trace encoder top
 * branch map based trace encoder emitting start, branch and address packets
 */
module trace_encoder import trace_core_pkg::*, trace_pkt_pkg::*; #(
    parameter int unsigned MAP_LEN = 31
) (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       enable_i,
    input  retire_s    retire_i,
    output logic       pkt_valid_o,
    output trace_pkt_s pkt_o
);

    logic                     map_push;
    logic                     map_taken;
    logic                     map_flush;
    logic                     map_full;
    logic [MAP_FIELD_LEN-1:0] map;
    logic [BRANCHES_LEN-1:0]  branches;
    logic                     addr_load;
    logic [31:0]              delta;
    logic                     emit;
    pkt_format_e              emit_fmt;

    packet_select #(
        .MAP_LEN(MAP_LEN)
    ) packet_select_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .enable_i   (enable_i),
        .retire_i   (retire_i),
        .map_full_i (map_full),
        .map_push_o (map_push),
        .map_taken_o(map_taken),
        .map_flush_o(map_flush),
        .addr_load_o(addr_load),
        .emit_o     (emit),
        .emit_fmt_o (emit_fmt)
    );

    branch_map #(
        .MAP_LEN(MAP_LEN)
    ) branch_map_i (
        .clk       (clk),
        .reset_i   (reset_i),
        .push_i    (map_push),
        .taken_i   (map_taken),
        .flush_i   (map_flush),
        .map_o     (map),
        .branches_o(branches),
        .full_o    (map_full),
        .empty_o   ()
    );

    addr_delta addr_delta_i (
        .clk    (clk),
        .reset_i(reset_i),
        .load_i (addr_load),
        .iaddr_i(retire_i.iaddr),
        .delta_o(delta)
    );

    packet_emitter packet_emitter_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .emit_i     (emit),
        .fmt_i      (emit_fmt),
        .map_i      (map),
        .branches_i (branches),
        .iaddr_i    (retire_i.iaddr),
        .delta_i    (delta),
        .pkt_valid_o(pkt_valid_o),
        .pkt_o      (pkt_o)
    );

endmodule

//--- logic/addr_delta.sv
/*
 * address delta
 * holds the last reported address and gives the difference to the current one
 */
module addr_delta (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        load_i,
    input  logic [31:0] iaddr_i,
    output logic [31:0] delta_o
);

    logic [31:0] last_addr_q;

    // updated by every start or address packet
    always_ff @(posedge clk) begin
        if (reset_i) begin
            last_addr_q <= '0;
        end else if (load_i) begin
            last_addr_q <= iaddr_i;
        end
    end

    // wraps modulo 2^32
    assign delta_o = iaddr_i - last_addr_q;

endmodule

//--- logic/branch_map.sv
/*
 * branch map
 * records conditional branch outcomes in arrival order with a running count
 */
module branch_map import trace_pkt_pkg::*; #(
    parameter int unsigned MAP_LEN = 31
) (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     push_i,
    input  logic                     taken_i,
    input  logic                     flush_i,
    output logic [MAP_FIELD_LEN-1:0] map_o,
    output logic [BRANCHES_LEN-1:0]  branches_o,
    output logic                     full_o,
    output logic                     empty_o
);

    logic [MAP_FIELD_LEN-1:0] map_q;
    logic [BRANCHES_LEN-1:0]  count_q;
    logic [BRANCHES_LEN-1:0]  count_d;
    logic [BRANCHES_LEN-1:0]  wr_pos;
    logic                     accept;
    logic [31:0]              valid_mask;

    // a flush restarts the map, so a pushed branch lands in bit 0
    assign wr_pos = flush_i ? '0 : count_q;

    // no room once full, unless the same cycle flushes
    assign accept = push_i && (flush_i || !full_o);

    always_comb begin
        count_d = count_q;
        if (flush_i) begin
            count_d = push_i ? BRANCHES_LEN'(1) : '0;
        end else if (accept) begin
            count_d = count_q + BRANCHES_LEN'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            count_q <= '0;
        end else begin
            count_q <= count_d;
        end
    end

    // outcome bits, taken is stored as 0
    always_ff @(posedge clk) begin
        if (accept) begin
            map_q[wr_pos] <= ~taken_i;
        end
    end

    // stale bits above the count are hidden
    assign valid_mask = (32'd1 << count_q) - 32'd1;

    assign map_o      = map_q & valid_mask[MAP_FIELD_LEN-1:0];
    assign branches_o = count_q;
    assign full_o     = (count_q == BRANCHES_LEN'(MAP_LEN));
    assign empty_o    = (count_q == '0);

endmodule

//--- sim.f
common/trace_core_pkg.sv
common/trace_pkt_pkg.sv
logic/branch_map.sv
logic/addr_delta.sv
encoder/packet_select.sv
encoder/packet_emitter.sv
encoder/trace_encoder.sv
sim/tb_trace_encoder.sv

//--- sim/tb_trace_encoder.sv
/*
 * trace encoder testbench
 * directed tests checked against a reference model of the branch map and packet rules
 */
module tb_trace_encoder
    import trace_core_pkg::*, trace_pkt_pkg::*;
();

    localparam int unsigned MAP_LEN = 8;
    localparam int          TIMEOUT = 20;

    logic       clk;
    logic       reset_i;
    logic       enable_i;
    retire_s    retire_i;
    logic       pkt_valid_o;
    trace_pkt_s pkt_o;

    // reference model state
    logic [MAP_FIELD_LEN-1:0] ref_map;
    int unsigned              ref_cnt;
    logic [31:0]              ref_last;
    logic                     ref_on;
    trace_pkt_s               exp_q[$];
    int                       exp_cyc_q[$];

    logic [31:0] lfsr;
    logic [31:0] pc;
    int          cyc;
    int          last_pkt_cyc;
    int          err_cnt;
    int          test_err_base;
    int          tests_run;
    int          tests_failed;

    trace_encoder #(
        .MAP_LEN(MAP_LEN)
    ) trace_encoder_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .enable_i   (enable_i),
        .retire_i   (retire_i),
        .pkt_valid_o(pkt_valid_o),
        .pkt_o      (pkt_o)
    );

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at cycle %0d: %s", cyc, msg);
        err_cnt++;
    endtask

    // predicted packet shows up after the edge that closes this cycle
    task automatic expect_pkt(input pkt_format_e fmt, input int unsigned branches,
                              input logic [MAP_FIELD_LEN-1:0] map, input logic [31:0] addr);
        trace_pkt_s p;
        p.format   = fmt;
        p.branches = BRANCHES_LEN'(branches);
        p.map      = map;
        p.address  = addr;
        exp_q.push_back(p);
        exp_cyc_q.push_back(cyc + 1);
    endtask

    // taken goes in as 0
    task automatic record_branch(input logic taken);
        ref_map[ref_cnt] = ~taken;
        ref_cnt++;
    endtask

    task automatic clear_map();
        ref_cnt = 0;
        ref_map = '0;
    endtask

    task automatic model_step(input retire_s r);
        logic is_branch;
        logic is_jump;
        is_branch = r.valid && (r.iclass == ICLASS_BRANCH);
        is_jump   = r.valid && (r.iclass == ICLASS_JUMP_UNINF);
        if (!enable_i) begin
            ref_on = 1'b0;
            clear_map();
        end else if (!ref_on) begin
            if (r.valid) begin
                expect_pkt(FMT_START, 0, '0, r.iaddr);
                ref_on   = 1'b1;
                ref_last = r.iaddr;
                clear_map();
                if (is_branch) begin
                    record_branch(r.taken);
                end
            end
        end else if (is_jump) begin
            // jump wins over a full map
            expect_pkt(FMT_ADDR, ref_cnt, ref_map, r.iaddr - ref_last);
            ref_last = r.iaddr;
            clear_map();
        end else if (ref_cnt == MAP_LEN) begin
            expect_pkt(FMT_BRANCH, MAP_LEN, ref_map, '0);
            clear_map();
            if (is_branch) begin
                record_branch(r.taken);
            end
        end else if (is_branch) begin
            record_branch(r.taken);
        end
    endtask

    // outputs are registers and are stable one unit after the edge
    task automatic tick();
        @(posedge clk);
        #1;
        cyc++;
        if (exp_q.size() > 0 && exp_cyc_q[0] < cyc) begin
            report_error("a predicted packet did not appear in its cycle");
            void'(exp_q.pop_front());
            void'(exp_cyc_q.pop_front());
        end
        if (pkt_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                report_error("a packet was sent when none was predicted");
            end else begin
                check("pkt_cycle", cyc, exp_cyc_q[0]);
                check("pkt_o.format", pkt_o.format, exp_q[0].format);
                check("pkt_o.branches", pkt_o.branches, exp_q[0].branches);
                check("pkt_o.map", pkt_o.map, exp_q[0].map);
                check("pkt_o.address", pkt_o.address, exp_q[0].address);
                void'(exp_q.pop_front());
                void'(exp_cyc_q.pop_front());
                last_pkt_cyc = cyc;
            end
        end
    endtask

    task automatic drive(input logic valid, input iclass_e iclass, input logic [31:0] iaddr,
                         input logic taken);
        retire_i.valid  = valid;
        retire_i.iclass = iclass;
        retire_i.iaddr  = iaddr;
        retire_i.taken  = taken;
        model_step(retire_i);
        tick();
    endtask

    task automatic idle();
        drive(1'b0, ICLASS_PLAIN, '0, 1'b0);
    endtask

    task automatic rand_branches(input int n);
        logic [31:0] b;
        for (int i = 0; i < n; i++) begin
            rand_bits(1, b);
            drive(1'b1, ICLASS_BRANCH, pc, b[0]);
            pc += 4;
        end
    endtask

    task automatic rand_jump();
        logic [31:0] target;
        rand_bits(32, target);
        drive(1'b1, ICLASS_JUMP_UNINF, target, 1'b0);
        pc = target + 4;
    endtask

    task automatic drain_packets();
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < TIMEOUT) begin
            idle();
            waited++;
        end
        if (exp_q.size() > 0) begin
            report_error("no packet within timeout");
            exp_q.delete();
            exp_cyc_q.delete();
        end
    endtask

    // a few quiet cycles catch stray packets
    task automatic finish_test(input string name);
        drain_packets();
        idle();
        idle();
        tests_run++;
        if (err_cnt == test_err_base) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, err_cnt - test_err_base);
        end
        test_err_base = err_cnt;
    endtask

    task automatic start_after_reset();
        int trig;
        repeat (3) idle();
        pc   = 32'h8000_0000;
        trig = cyc;
        drive(1'b1, ICLASS_PLAIN, pc, 1'b0);
        pc += 4;
        drain_packets();
        check("start latency", last_pkt_cyc - trig, 1);
        finish_test("start packet after reset");
    endtask

    task automatic full_map_branch();
        int trig;
        rand_branches(MAP_LEN - 1);
        trig = cyc;
        rand_branches(1);
        // the registered full flag costs one more cycle
        idle();
        drain_packets();
        check("branch latency", last_pkt_cyc - trig, 2);
        finish_test("branch packet on full map");
    endtask

    task automatic jump_address();
        int trig;
        rand_branches(3);
        trig = cyc;
        rand_jump();
        drain_packets();
        check("address latency", last_pkt_cyc - trig, 1);
        // second delta is relative to the first jump
        rand_branches(2);
        rand_jump();
        finish_test("address packets on jumps");
    endtask

    task automatic jump_on_full_map();
        rand_branches(MAP_LEN);
        rand_jump();
        drain_packets();
        // ninth branch lands in the flush cycle
        rand_branches(MAP_LEN + 1);
        rand_jump();
        finish_test("jump on full map");
    endtask

    task automatic enable_toggle();
        rand_branches(3);
        enable_i = 1'b0;
        rand_branches(4);
        rand_jump();
        drive(1'b1, ICLASS_PLAIN, pc, 1'b0);
        idle();
        enable_i = 1'b1;
        drive(1'b1, ICLASS_PLAIN, pc, 1'b0);
        pc += 4;
        rand_jump();
        finish_test("enable off and on");
    endtask

    task automatic random_stream();
        logic [31:0] kind;
        logic [31:0] b;
        for (int i = 0; i < 400; i++) begin
            rand_bits(3, kind);
            case (kind)
                0, 1, 2, 3: begin
                    rand_bits(1, b);
                    drive(1'b1, ICLASS_BRANCH, pc, b[0]);
                    pc += 4;
                end
                4: begin
                    drive(1'b1, ICLASS_PLAIN, pc, 1'b0);
                    pc += 4;
                end
                5: rand_jump();
                default: idle();
            endcase
        end
        finish_test("random stream");
    endtask

    initial begin
        lfsr          = 32'h2bc44177;
        reset_i       = 1'b1;
        enable_i      = 1'b1;
        retire_i      = '0;
        pc            = '0;
        cyc           = 0;
        last_pkt_cyc  = -1;
        err_cnt       = 0;
        test_err_base = 0;
        tests_run     = 0;
        tests_failed  = 0;
        ref_on        = 1'b0;
        ref_last      = '0;
        clear_map();
        repeat (3) @(posedge clk);
        #1;
        reset_i = 1'b0;

        start_after_reset();
        full_map_branch();
        jump_address();
        jump_on_full_map();
        enable_toggle();
        random_stream();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
